//--- source/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

	//////////////////////////////////////////////////
	// Frame format
	//////////////////////////////////////////////////

	// Data bits per frame, LSB first on the line
	localparam int data_bits = 8;

	// One payload byte
	typedef logic [data_bits-1:0] data_t;

	// Data bit counter, 0 to 8
	typedef logic [3:0] bit_idx_t;

	//////////////////////////////////////////////////
	// Serial engine states
	//////////////////////////////////////////////////

	// Transmitter
	typedef enum logic [1:0] {
		tx_st_idle  = 2'd0,
		tx_st_start = 2'd1,
		tx_st_data  = 2'd2,
		tx_st_stop  = 2'd3
	} tx_state_t;

	// Receiver
	typedef enum logic [1:0] {
		rx_st_idle  = 2'd0,
		rx_st_start = 2'd1,
		rx_st_data  = 2'd2,
		rx_st_stop  = 2'd3
	} rx_state_t;

endpackage

`default_nettype wire

//--- source/uart_baud_pkg.sv
`default_nettype none

package uart_baud_pkg;

	//////////////////////////////////////////////////
	// Baud timing
	//////////////////////////////////////////////////

	// System clocks per oversampling tick, small for short sims
	localparam int clk_per_tick = 4;

	// Oversampling ratio, ticks per bit
	localparam int ticks_per_bit = 16;

	// Divider counter and tick-in-bit counter
	typedef logic [$clog2(clk_per_tick)-1:0] tick_div_t;
	typedef logic [$clog2(ticks_per_bit)-1:0] tick_cnt_t;

	// Last divider count, tick strobe fires on wrap
	localparam tick_div_t div_last = tick_div_t'(clk_per_tick - 1);

	// Tick count at the end of a full bit and at mid bit
	localparam tick_cnt_t bit_end = tick_cnt_t'(ticks_per_bit - 1);
	localparam tick_cnt_t bit_mid = tick_cnt_t'(ticks_per_bit / 2 - 1);

endpackage

`default_nettype wire

//--- source/uart_baud_tick.sv
`default_nettype none

module uart_baud_tick (
	input  logic clk,
	input  logic rst_n,
	output logic tick
);

	//////////////////////////////////////////////////
	// Clock divider
	//////////////////////////////////////////////////

	// Free-running count of system clocks
	uart_baud_pkg::tick_div_t div_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end
		else
		begin
			// Wrap at clk_per_tick
			if (div_cnt == uart_baud_pkg::div_last)
			begin
				div_cnt <= '0;
			end
			else
			begin
				div_cnt <= div_cnt + 1'b1;
			end
			// Registered strobe, one clock wide on the wrap
			tick <= (div_cnt == uart_baud_pkg::div_last);
		end
	end

endmodule

`default_nettype wire

//--- source/uart_tx.sv
`default_nettype none

module uart_tx (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,
	input  uart_frame_pkg::data_t tx_data,
	input  logic                  tx_start,
	output logic                  tx_busy,
	output logic                  tx
);

	//////////////////////////////////////////////////
	// State and datapath registers
	//////////////////////////////////////////////////

	uart_frame_pkg::tx_state_t state;

	// Byte being shifted out, LSB first
	uart_frame_pkg::data_t     shreg;

	// Data bits already put on the line
	uart_frame_pkg::bit_idx_t  bit_idx;

	// Ticks elapsed in the current bit
	uart_baud_pkg::tick_cnt_t  tick_cnt;

	//////////////////////////////////////////////////
	// Transmit FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= uart_frame_pkg::tx_st_idle;
			shreg    <= '0;
			bit_idx  <= '0;
			tick_cnt <= '0;
			tx_busy  <= 1'b0;
			tx       <= 1'b1;
		end
		else
		begin
			case (state)
				uart_frame_pkg::tx_st_idle:
				begin
					// Accept only here, strobes while busy are dropped
					if (tx_start)
					begin
						shreg   <= tx_data;
						tx_busy <= 1'b1;
						state   <= uart_frame_pkg::tx_st_start;
					end
				end
				uart_frame_pkg::tx_st_start:
				begin
					if (tick)
					begin
						// Line still high, start bit goes out on this first tick
						if (tx)
						begin
							tx       <= 1'b0;
							tick_cnt <= '0;
						end
						else if (tick_cnt == uart_baud_pkg::bit_end)
						begin
							// Start bit done, first data bit
							tx       <= shreg[0];
							shreg    <= shreg >> 1;
							bit_idx  <= uart_frame_pkg::bit_idx_t'(1);
							tick_cnt <= '0;
							state    <= uart_frame_pkg::tx_st_data;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_frame_pkg::tx_st_data:
				begin
					if (tick)
					begin
						if (tick_cnt == uart_baud_pkg::bit_end)
						begin
							tick_cnt <= '0;
							if (bit_idx == uart_frame_pkg::bit_idx_t'(uart_frame_pkg::data_bits))
							begin
								// All eight sent, stop bit
								tx    <= 1'b1;
								state <= uart_frame_pkg::tx_st_stop;
							end
							else
							begin
								tx      <= shreg[0];
								shreg   <= shreg >> 1;
								bit_idx <= bit_idx + 1'b1;
							end
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_frame_pkg::tx_st_stop:
				begin
					if (tick)
					begin
						// Busy drops on the tick that closes the stop bit
						if (tick_cnt == uart_baud_pkg::bit_end)
						begin
							tick_cnt <= '0;
							tx_busy  <= 1'b0;
							state    <= uart_frame_pkg::tx_st_idle;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				default:
				begin
					state <= uart_frame_pkg::tx_st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/uart_rx.sv
`default_nettype none

module uart_rx (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  tick,
	input  logic                  rx,
	output uart_frame_pkg::data_t rx_data,
	output logic                  rx_valid,
	output logic                  rx_frame_err
);

	//////////////////////////////////////////////////
	// Input synchronizer
	//////////////////////////////////////////////////

	// Two flops, idle line is high
	logic rx_meta;
	logic rx_sync;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	//////////////////////////////////////////////////
	// Receive FSM
	//////////////////////////////////////////////////

	uart_frame_pkg::rx_state_t state;

	// Assembled byte, new bits enter at the MSB
	uart_frame_pkg::data_t     shreg;

	// Data bits sampled so far
	uart_frame_pkg::bit_idx_t  bit_idx;

	// Ticks since the last sample point
	uart_baud_pkg::tick_cnt_t  tick_cnt;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= uart_frame_pkg::rx_st_idle;
			shreg        <= '0;
			bit_idx      <= '0;
			tick_cnt     <= '0;
			rx_data      <= '0;
			rx_valid     <= 1'b0;
			rx_frame_err <= 1'b0;
		end
		else
		begin
			// Strobes last one clock
			rx_valid     <= 1'b0;
			rx_frame_err <= 1'b0;
			case (state)
				uart_frame_pkg::rx_st_idle:
				begin
					// Low level, possible start bit
					if (!rx_sync)
					begin
						tick_cnt <= '0;
						bit_idx  <= '0;
						state    <= uart_frame_pkg::rx_st_start;
					end
				end
				uart_frame_pkg::rx_st_start:
				begin
					if (tick)
					begin
						// Half a bit in, re-check the line
						if (tick_cnt == uart_baud_pkg::bit_mid)
						begin
							tick_cnt <= '0;
							if (rx_sync)
							begin
								// Glitch, back to idle
								state <= uart_frame_pkg::rx_st_idle;
							end
							else
							begin
								state <= uart_frame_pkg::rx_st_data;
							end
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_frame_pkg::rx_st_data:
				begin
					if (tick)
					begin
						// Centre of a data bit, one full bit after previous sample
						if (tick_cnt == uart_baud_pkg::bit_end)
						begin
							tick_cnt <= '0;
							shreg    <= {rx_sync, shreg[uart_frame_pkg::data_bits-1:1]};
							bit_idx  <= bit_idx + 1'b1;
							if (bit_idx == uart_frame_pkg::bit_idx_t'(uart_frame_pkg::data_bits - 1))
							begin
								state <= uart_frame_pkg::rx_st_stop;
							end
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				uart_frame_pkg::rx_st_stop:
				begin
					if (tick)
					begin
						// Stop bit sample decides valid or framing error
						if (tick_cnt == uart_baud_pkg::bit_end)
						begin
							tick_cnt <= '0;
							if (rx_sync)
							begin
								rx_data  <= shreg;
								rx_valid <= 1'b1;
							end
							else
							begin
								rx_frame_err <= 1'b1;
							end
							state <= uart_frame_pkg::rx_st_idle;
						end
						else
						begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
				end
				default:
				begin
					state <= uart_frame_pkg::rx_st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/uart_top.sv
`default_nettype none

module uart_top (
	input  logic                  clk,
	input  logic                  rst_n,
	// Transmit side
	input  uart_frame_pkg::data_t tx_data,
	input  logic                  tx_start,
	output logic                  tx_busy,
	output logic                  tx,
	// Receive side
	input  logic                  rx,
	output uart_frame_pkg::data_t rx_data,
	output logic                  rx_valid,
	output logic                  rx_frame_err
);

	//////////////////////////////////////////////////
	// Shared oversampling tick
	//////////////////////////////////////////////////

	logic tick;

	uart_baud_tick tick0 (
		.clk   (clk),
		.rst_n (rst_n),
		.tick  (tick)
	);

	//////////////////////////////////////////////////
	// Serial engines
	//////////////////////////////////////////////////

	uart_tx tx0 (
		.clk      (clk),
		.rst_n    (rst_n),
		.tick     (tick),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

	// Line comes in from outside, loopback is closed there
	uart_rx rx0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.tick         (tick),
		.rx           (rx),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err)
	);

endmodule

`default_nettype wire

//--- dv/uart_tb.sv
`default_nettype none

module uart_tb;

	//////////////////////////////////////////////////
	// Timing and table sizes
	//////////////////////////////////////////////////

	// One bit on the line in system clocks
	localparam int bit_clks = uart_baud_pkg::ticks_per_bit * uart_baud_pkg::clk_per_tick;
	localparam int frame_bits = uart_frame_pkg::data_bits + 2;
	localparam int num_tests = 14;
	localparam int cycle_limit = num_tests * bit_clks * frame_bits * 2 + 200;

	// Table modes
	localparam int mode_send = 0;
	localparam int mode_busy = 1;
	localparam int mode_bad_stop = 2;
	localparam int mode_glitch = 3;

	logic clk;
	logic rst_n;
	uart_frame_pkg::data_t tx_data;
	logic tx_start;
	logic tx_busy;
	logic tx;
	logic rx_line;
	uart_frame_pkg::data_t rx_data;
	logic rx_valid;
	logic rx_frame_err;

	// Line select, low for loopback, high for the testbench line
	logic line_sel;
	logic tb_line;

	assign rx_line = line_sel ? tb_line : tx;

	uart_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.tx_data      (tx_data),
		.tx_start     (tx_start),
		.tx_busy      (tx_busy),
		.tx           (tx),
		.rx           (rx_line),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_frame_err (rx_frame_err)
	);

	// Stimulus and expected receive outcome
	int mode_tab [num_tests];
	uart_frame_pkg::data_t byte_tab [num_tests];
	int exp_valid_tab [num_tests];
	int exp_err_tab [num_tests];

	int errors = 0;
	int valid_cnt = 0;
	int err_cnt = 0;
	int overlap_cnt = 0;
	int cycle_cnt = 0;
	uart_frame_pkg::data_t last_rx = '0;

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Monitors
	//////////////////////////////////////////////////

	// Strobe counts, sampled mid cycle
	always @(negedge clk)
	begin
		if (rx_valid)
		begin
			valid_cnt <= valid_cnt + 1;
			last_rx <= rx_data;
		end
		if (rx_frame_err)
		begin
			err_cnt <= err_cnt + 1;
		end
		if (rx_valid && rx_frame_err)
		begin
			overlap_cnt <= overlap_cnt + 1;
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
		begin
			$display("Timeout: run exceeded %0d clock cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic uart_frame_pkg::data_t rand_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	function automatic string mode_name(input int mode);
		case (mode)
			mode_send: return "send";
			mode_busy: return "send-while-busy";
			mode_bad_stop: return "bad-stop";
			default: return "glitch";
		endcase
	endfunction

	task automatic fill_entry(input int idx, input int mode, input uart_frame_pkg::data_t b,
		input int exp_valid, input int exp_err);
		mode_tab[idx] = mode;
		byte_tab[idx] = b;
		exp_valid_tab[idx] = exp_valid;
		exp_err_tab[idx] = exp_err;
	endtask

	// One-cycle start strobe
	task automatic send_byte(input uart_frame_pkg::data_t b);
		@(posedge clk);
		tx_data <= b;
		tx_start <= 1'b1;
		@(posedge clk);
		tx_start <= 1'b0;
	endtask

	// Hold the testbench line at one level, starts on a rising edge
	task automatic drive_bit(input logic v, input int clks);
		tb_line <= v;
		repeat (clks) @(posedge clk);
	endtask

	// Start bit, LSB first data, stop bit, sampled mid bit
	task automatic check_line(input uart_frame_pkg::data_t b, input bit inject);
		int i;
		int n;
		int wait_clks;
		logic exp_bit;
		uart_frame_pkg::data_t sh;
		n = 0;
		sh = b;
		@(negedge clk);
		// Busy rises on the clock after the accepted strobe
		if (tx_busy !== 1'b1)
		begin
			$display("ERR time=%0t tx_busy expected 1 got %b", $time, tx_busy);
			errors++;
		end
		// Start bit goes out on the next tick
		while (tx !== 1'b0 && n < uart_baud_pkg::clk_per_tick)
		begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b0)
		begin
			$display("No start bit on tx within %0d clocks of tx_start",
				uart_baud_pkg::clk_per_tick);
			errors++;
		end
		else
		begin
			for (i = 0; i < frame_bits; i++)
			begin
				wait_clks = (i == 0) ? bit_clks / 2 : bit_clks;
				// Injected strobe already used one clock
				if (inject && i == 1)
					wait_clks = bit_clks - 1;
				repeat (wait_clks) @(negedge clk);
				if (i == 0)
					exp_bit = 1'b0;
				else if (i == frame_bits - 1)
					exp_bit = 1'b1;
				else
				begin
					exp_bit = sh[0];
					sh = sh >> 1;
				end
				if (tx !== exp_bit)
				begin
					$display("ERR time=%0t tx bit %0d expected %b got %b", $time, i, exp_bit, tx);
					errors++;
				end
				// Busy holds for the whole frame
				if (tx_busy !== 1'b1)
				begin
					$display("ERR time=%0t tx_busy expected 1 got %b", $time, tx_busy);
					errors++;
				end
				// Second start mid start bit, must be dropped
				if (inject && i == 0)
				begin
					@(posedge clk);
					tx_data <= ~b;
					tx_start <= 1'b1;
					@(posedge clk);
					tx_start <= 1'b0;
				end
			end
			n = 0;
			while (tx_busy && n < bit_clks)
			begin
				@(negedge clk);
				n++;
			end
			if (tx_busy)
			begin
				$display("tx_busy did not fall within %0d clocks of the stop bit", bit_clks);
				errors++;
			end
		end
	endtask

	task automatic drive_bad_frame(input uart_frame_pkg::data_t b);
		int i;
		uart_frame_pkg::data_t sh;
		sh = b;
		@(posedge clk);
		line_sel <= 1'b1;
		drive_bit(1'b1, bit_clks);
		drive_bit(1'b0, bit_clks);
		for (i = 0; i < uart_frame_pkg::data_bits; i++)
		begin
			drive_bit(sh[0], bit_clks);
			sh = sh >> 1;
		end
		// Low stop bit, cut short so the retrigger on it fails the start check
		drive_bit(1'b0, bit_clks * 3 / 4);
		drive_bit(1'b1, 2 * bit_clks);
	endtask

	// Low pulse of two ticks
	task automatic drive_glitch();
		@(posedge clk);
		line_sel <= 1'b1;
		drive_bit(1'b1, bit_clks);
		drive_bit(1'b0, 2 * uart_baud_pkg::clk_per_tick);
		drive_bit(1'b1, 3 * bit_clks);
	endtask

	task automatic run_test(input int idx, output bit ok);
		int err0;
		int v0;
		int e0;
		int dv;
		int de;
		err0 = errors;
		v0 = valid_cnt;
		e0 = err_cnt;
		case (mode_tab[idx])
			mode_send, mode_busy:
			begin
				@(posedge clk);
				line_sel <= 1'b0;
				send_byte(byte_tab[idx]);
				check_line(byte_tab[idx], mode_tab[idx] == mode_busy);
			end
			mode_bad_stop: drive_bad_frame(byte_tab[idx]);
			default: drive_glitch();
		endcase
		// Quiet window, late or extra strobes land here
		repeat (2 * bit_clks) @(negedge clk);
		if (tx_busy)
		begin
			$display("Transmitter busy after the frame, a dropped start was taken");
			errors++;
		end
		dv = valid_cnt - v0;
		de = err_cnt - e0;
		if (dv == 0 && exp_valid_tab[idx] > 0)
		begin
			$display("No rx_valid strobe in test %0d", idx);
			errors++;
		end
		else if (dv != exp_valid_tab[idx])
		begin
			$display("ERR time=%0t rx_valid count expected %0d got %0d",
				$time, exp_valid_tab[idx], dv);
			errors++;
		end
		if (de == 0 && exp_err_tab[idx] > 0)
		begin
			$display("No rx_frame_err strobe in test %0d", idx);
			errors++;
		end
		else if (de != exp_err_tab[idx])
		begin
			$display("ERR time=%0t rx_frame_err count expected %0d got %0d",
				$time, exp_err_tab[idx], de);
			errors++;
		end
		if (exp_valid_tab[idx] == 1 && dv == 1 && last_rx !== byte_tab[idx])
		begin
			$display("ERR time=%0t rx_data expected %h got %h", $time, byte_tab[idx], last_rx);
			errors++;
		end
		ok = (errors == err0);
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int unsigned seed_ret;
		int i;
		int passed;
		int failed;
		bit ok;
		rst_n = 1'b0;
		tx_data = '0;
		tx_start = 1'b0;
		line_sel = 1'b0;
		tb_line = 1'b1;
		passed = 0;
		failed = 0;
		// Seed once, then fill the table
		seed_ret = $urandom(71);
		fill_entry(0, mode_send, 8'h00, 1, 0);
		fill_entry(1, mode_send, 8'hFF, 1, 0);
		fill_entry(2, mode_send, 8'h55, 1, 0);
		fill_entry(3, mode_send, 8'hA5, 1, 0);
		fill_entry(4, mode_send, 8'h01, 1, 0);
		fill_entry(5, mode_send, 8'h80, 1, 0);
		fill_entry(6, mode_busy, rand_byte(), 1, 0);
		fill_entry(7, mode_bad_stop, rand_byte(), 0, 1);
		fill_entry(8, mode_send, rand_byte(), 1, 0);
		fill_entry(9, mode_glitch, 8'h00, 0, 0);
		fill_entry(10, mode_send, rand_byte(), 1, 0);
		fill_entry(11, mode_busy, rand_byte(), 1, 0);
		fill_entry(12, mode_bad_stop, rand_byte(), 0, 1);
		fill_entry(13, mode_send, rand_byte(), 1, 0);

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Reset values, then an idle line
		@(negedge clk);
		if (tx !== 1'b1)
		begin
			$display("ERR time=%0t tx expected 1 got %b", $time, tx);
			errors++;
		end
		if (tx_busy !== 1'b0)
		begin
			$display("ERR time=%0t tx_busy expected 0 got %b", $time, tx_busy);
			errors++;
		end
		if (rx_data !== '0)
		begin
			$display("ERR time=%0t rx_data expected 00 got %h", $time, rx_data);
			errors++;
		end
		repeat (4 * bit_clks) @(negedge clk);
		if (valid_cnt != 0 || err_cnt != 0)
		begin
			$display("Receive strobe seen on an idle line after reset");
			errors++;
		end
		if (errors == 0)
			passed++;
		else
			failed++;
		$display("test reset: %s", (errors == 0) ? "ok" : "failed");

		for (i = 0; i < num_tests; i++)
		begin
			run_test(i, ok);
			if (ok)
				passed++;
			else
				failed++;
			$display("test %0d %s byte %h: %s", i, mode_name(mode_tab[i]), byte_tab[i],
				ok ? "ok" : "failed");
		end

		if (overlap_cnt != 0)
		begin
			$display("rx_valid and rx_frame_err were high together %0d times", overlap_cnt);
			errors++;
		end
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			num_tests + 1, passed, failed, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
source/uart_frame_pkg.sv
source/uart_baud_pkg.sv
source/uart_baud_tick.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
dv/uart_tb.sv

//--- Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall
SIM_FLAGS  := --binary --timing -j 0
TOP        := uart_tb
RTL_TOP    := uart_top
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS

# Design sources only, taken from the file list
RTL_SRCS := $(shell grep '^source/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	rm -f $(LOG)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
